// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Byte width shared by data, addresses and instructions
    localparam int DATA_W = 8;

    typedef logic [DATA_W-1:0] word_t;

    // Bus address driven whenever no load or store is in flight
    localparam word_t RESET_BUS_ADDR = 8'hFF;

    // ROM locations holding the thread start addresses
    localparam word_t IRQ_VECTOR_A = 8'hFF;
    localparam word_t IRQ_VECTOR_B = 8'hFE;

    // High nibble marking a load as an immediate load
    localparam logic [3:0] IMM_MARK = 4'hF;

    // Low nibble of an instruction byte.
    // Bit 0 picks register B for the load, store and math pairs.
    typedef enum logic [3:0] {
        INSTR_LOAD_A  = 4'h0,
        INSTR_LOAD_B  = 4'h1,
        INSTR_STORE_A = 4'h2,
        INSTR_STORE_B = 4'h3,
        INSTR_MATH_A  = 4'h4,
        INSTR_MATH_B  = 4'h5,
        INSTR_BRANCH  = 4'h6,
        INSTR_GOTO    = 4'h7,
        INSTR_IDLE    = 4'h8,
        INSTR_CALL    = 4'h9,
        INSTR_RETURN  = 4'hA
    } instr_e;

    // High nibble of a math or branch instruction
    typedef enum logic [3:0] {
        ALU_ADD   = 4'h0,
        ALU_SUB   = 4'h1,
        ALU_AND   = 4'h2,
        ALU_OR    = 4'h3,
        ALU_XOR   = 4'h4,
        ALU_SHL_A = 4'h5,
        ALU_SHR_A = 4'h6,
        ALU_INC_A = 4'h7,
        ALU_INC_B = 4'h8,
        ALU_DEC_A = 4'h9,
        ALU_DEC_B = 4'hA,
        ALU_EQ    = 4'hB,
        ALU_GT    = 4'hC,
        ALU_LT    = 4'hD,
        ALU_INV_A = 4'hE
    } alu_op_e;

    // Control FSM states
    typedef enum logic [4:0] {
        ST_IDLE          = 5'h00,
        ST_THREAD_ACK    = 5'h01,
        ST_THREAD_VECTOR = 5'h02,
        ST_FETCH         = 5'h03,
        ST_CHOOSE_OP     = 5'h04,
        ST_LOAD_ADDR     = 5'h05,
        ST_LOAD_WAIT     = 5'h06,
        ST_LOAD_DATA     = 5'h07,
        ST_IMMEDIATE     = 5'h08,
        ST_STORE         = 5'h09,
        ST_MATH          = 5'h0A,
        ST_BRANCH_CHECK  = 5'h0B,
        ST_BRANCH_TAKEN  = 5'h0C,
        ST_GOTO          = 5'h0D,
        ST_CALL          = 5'h0E,
        ST_RETURN        = 5'h0F
    } state_e;

    // Program counter commands
    typedef enum logic [2:0] {
        PC_HOLD         = 3'd0,
        PC_PLUS_ONE     = 3'd1,
        PC_PLUS_TWO     = 3'd2,
        PC_LOAD_ROM     = 3'd3,
        PC_LOAD_CONTEXT = 3'd4,
        PC_VECTOR_A     = 3'd5,
        PC_VECTOR_B     = 3'd6
    } pc_op_e;

    // Datapath commands
    typedef enum logic [2:0] {
        DP_NONE     = 3'd0,
        DP_ADDR_ROM = 3'd1,
        DP_LOAD_BUS = 3'd2,
        DP_LOAD_IMM = 3'd3,
        DP_STORE    = 3'd4,
        DP_ALU      = 3'd5
    } dp_op_e;

endpackage

`default_nettype wire

// ==== src/cpu_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
    input  logic             CLK,
    input  logic             RESET,
    input  cpu_pkg::word_t   reg_a,
    input  cpu_pkg::word_t   reg_b,
    input  cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::word_t   result
);

    cpu_pkg::word_t next_result;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:   next_result = reg_a + reg_b;
            cpu_pkg::ALU_SUB:   next_result = reg_a - reg_b;
            cpu_pkg::ALU_AND:   next_result = reg_a & reg_b;
            cpu_pkg::ALU_OR:    next_result = reg_a | reg_b;
            cpu_pkg::ALU_XOR:   next_result = reg_a ^ reg_b;
            // Logical shifts by one, zero fill
            cpu_pkg::ALU_SHL_A: next_result = reg_a << 1;
            cpu_pkg::ALU_SHR_A: next_result = reg_a >> 1;
            cpu_pkg::ALU_INC_A: next_result = reg_a + 8'd1;
            cpu_pkg::ALU_INC_B: next_result = reg_b + 8'd1;
            cpu_pkg::ALU_DEC_A: next_result = reg_a - 8'd1;
            cpu_pkg::ALU_DEC_B: next_result = reg_b - 8'd1;
            // Compares give 1 or 0, read by the branch check
            cpu_pkg::ALU_EQ:    next_result = cpu_pkg::word_t'(reg_a == reg_b);
            cpu_pkg::ALU_GT:    next_result = cpu_pkg::word_t'(reg_a > reg_b);
            cpu_pkg::ALU_LT:    next_result = cpu_pkg::word_t'(reg_a < reg_b);
            cpu_pkg::ALU_INV_A: next_result = ~reg_a;
            // Nibble F has no operation
            default:            next_result = '0;
        endcase
    end

    // Valid one cycle after the opcode shows on the ROM output
    always_ff @(posedge CLK) begin
        if (RESET) begin
            result <= '0;
        end else begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_pc_unit (
    input  logic            CLK,
    input  logic            RESET,
    input  cpu_pkg::pc_op_e pc_op,
    input  logic            offset_step,
    input  logic            save_context,
    input  cpu_pkg::word_t  rom_data,
    output cpu_pkg::word_t  rom_address
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t next_pc;
    cpu_pkg::word_t ret_addr;
    // Fetch offset of zero or one
    logic           offset;

    always_comb begin
        case (pc_op)
            cpu_pkg::PC_PLUS_ONE:     next_pc = pc + 8'd1;
            cpu_pkg::PC_PLUS_TWO:     next_pc = pc + 8'd2;
            // Jump target or thread start taken straight off the ROM
            cpu_pkg::PC_LOAD_ROM:     next_pc = rom_data;
            cpu_pkg::PC_LOAD_CONTEXT: next_pc = ret_addr;
            cpu_pkg::PC_VECTOR_A:     next_pc = cpu_pkg::IRQ_VECTOR_A;
            cpu_pkg::PC_VECTOR_B:     next_pc = cpu_pkg::IRQ_VECTOR_B;
            default:                  next_pc = pc;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc       <= '0;
            offset   <= 1'b0;
            ret_addr <= '0;
        end else begin
            pc <= next_pc;
            // Falls back to zero unless stepped
            offset <= offset_step;
            // Return lands after the two-byte call
            if (save_context) begin
                ret_addr <= pc + 8'd2;
            end
        end
    end

    // Offset reaches the operand byte of the current instruction
    assign rom_address = pc + cpu_pkg::word_t'(offset);

endmodule

`default_nettype wire

// ==== src/cpu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath (
    input  logic            CLK,
    input  logic            RESET,
    input  cpu_pkg::dp_op_e dp_op,
    input  logic            use_b,
    input  cpu_pkg::word_t  rom_data,
    input  cpu_pkg::word_t  bus_data_in,
    input  cpu_pkg::word_t  alu_result,
    output cpu_pkg::word_t  reg_a,
    output cpu_pkg::word_t  reg_b,
    output cpu_pkg::word_t  bus_addr,
    output cpu_pkg::word_t  bus_data_out,
    output logic            bus_we
);

    cpu_pkg::word_t load_value;
    logic           load_en;

    // Source for a register write
    always_comb begin
        load_en = 1'b1;
        case (dp_op)
            cpu_pkg::DP_LOAD_BUS: load_value = bus_data_in;
            cpu_pkg::DP_LOAD_IMM: load_value = rom_data;
            cpu_pkg::DP_ALU:      load_value = alu_result;
            default: begin
                load_value = alu_result;
                load_en    = 1'b0;
            end
        endcase
    end

    // Registers A and B
    always_ff @(posedge CLK) begin
        if (RESET) begin
            reg_a <= '0;
            reg_b <= '0;
        end else if (load_en) begin
            if (use_b) begin
                reg_b <= load_value;
            end else begin
                reg_a <= load_value;
            end
        end
    end

    // Bus address parks at FF outside load and store cycles
    always_ff @(posedge CLK) begin
        if (RESET) begin
            bus_addr <= cpu_pkg::RESET_BUS_ADDR;
            bus_we   <= 1'b0;
        end else begin
            if ((dp_op == cpu_pkg::DP_ADDR_ROM) || (dp_op == cpu_pkg::DP_STORE)) begin
                bus_addr <= rom_data;
            end else begin
                bus_addr <= cpu_pkg::RESET_BUS_ADDR;
            end
            bus_we <= (dp_op == cpu_pkg::DP_STORE);
        end
    end

    // Store data, valid alongside the strobe
    always_ff @(posedge CLK) begin
        if (dp_op == cpu_pkg::DP_STORE) begin
            bus_data_out <= use_b ? reg_b : reg_a;
        end
    end

    // Write strobe is a single-cycle pulse
    a_we_pulse: assert property (@(posedge CLK) disable iff (RESET)
        bus_we |=> !bus_we);

endmodule

`default_nettype wire

// ==== src/cpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
    input  logic            CLK,
    input  logic            RESET,
    input  cpu_pkg::word_t  rom_data,
    input  cpu_pkg::word_t  alu_result,
    input  logic [1:0]      irq_raise,
    output logic [1:0]      irq_ack,
    output cpu_pkg::pc_op_e pc_op,
    output logic            offset_step,
    output logic            save_context,
    output cpu_pkg::dp_op_e dp_op,
    output logic            use_b
);

    cpu_pkg::state_e state;
    cpu_pkg::state_e next_state;
    logic [1:0]      next_irq_ack;
    logic            sel_b;
    cpu_pkg::instr_e instr;
    logic            imm_load;

    // Decode fields of the instruction byte seen in choose-op
    assign instr    = cpu_pkg::instr_e'(rom_data[3:0]);
    assign imm_load = (rom_data[7:4] == cpu_pkg::IMM_MARK);
    assign use_b    = sel_b;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            // Start through the fetch wait, so address 0 reaches choose-op
            state   <= cpu_pkg::ST_FETCH;
            irq_ack <= 2'b00;
            sel_b   <= 1'b0;
        end else begin
            state   <= next_state;
            irq_ack <= next_irq_ack;
            // Register pick is bit 0 of the instruction code
            if (state == cpu_pkg::ST_CHOOSE_OP) begin
                sel_b <= rom_data[0];
            end
        end
    end

    always_comb begin
        next_state   = state;
        next_irq_ack = 2'b00;
        pc_op        = cpu_pkg::PC_HOLD;
        offset_step  = 1'b0;
        save_context = 1'b0;
        dp_op        = cpu_pkg::DP_NONE;

        case (state)
            // Sleep until an interrupt, line 0 first
            cpu_pkg::ST_IDLE: begin
                if (irq_raise[0]) begin
                    next_state   = cpu_pkg::ST_THREAD_ACK;
                    next_irq_ack = 2'b01;
                    pc_op        = cpu_pkg::PC_VECTOR_A;
                end else if (irq_raise[1]) begin
                    next_state   = cpu_pkg::ST_THREAD_ACK;
                    next_irq_ack = 2'b10;
                    pc_op        = cpu_pkg::PC_VECTOR_B;
                end
            end
            // Vector address goes to the ROM
            cpu_pkg::ST_THREAD_ACK: begin
                next_state = cpu_pkg::ST_THREAD_VECTOR;
            end
            // Thread start address is on the ROM output
            cpu_pkg::ST_THREAD_VECTOR: begin
                pc_op      = cpu_pkg::PC_LOAD_ROM;
                next_state = cpu_pkg::ST_FETCH;
            end
            // New counter settles; offset set so choose-op already fetches the operand
            cpu_pkg::ST_FETCH: begin
                offset_step = 1'b1;
                next_state  = cpu_pkg::ST_CHOOSE_OP;
            end
            cpu_pkg::ST_CHOOSE_OP: begin
                offset_step = 1'b1;
                case (instr)
                    cpu_pkg::INSTR_LOAD_A,
                    cpu_pkg::INSTR_LOAD_B: begin
                        next_state = imm_load ? cpu_pkg::ST_IMMEDIATE
                                              : cpu_pkg::ST_LOAD_ADDR;
                    end
                    cpu_pkg::INSTR_STORE_A,
                    cpu_pkg::INSTR_STORE_B: next_state = cpu_pkg::ST_STORE;
                    cpu_pkg::INSTR_MATH_A,
                    cpu_pkg::INSTR_MATH_B:  next_state = cpu_pkg::ST_MATH;
                    cpu_pkg::INSTR_BRANCH:  next_state = cpu_pkg::ST_BRANCH_CHECK;
                    cpu_pkg::INSTR_GOTO:    next_state = cpu_pkg::ST_GOTO;
                    cpu_pkg::INSTR_CALL:    next_state = cpu_pkg::ST_CALL;
                    cpu_pkg::INSTR_RETURN:  next_state = cpu_pkg::ST_RETURN;
                    // Idle and unused codes both end the thread
                    default:                next_state = cpu_pkg::ST_IDLE;
                endcase
            end
            // Operand byte is the data address
            cpu_pkg::ST_LOAD_ADDR: begin
                dp_op      = cpu_pkg::DP_ADDR_ROM;
                pc_op      = cpu_pkg::PC_PLUS_TWO;
                next_state = cpu_pkg::ST_LOAD_WAIT;
            end
            // Address on the bus, memory samples it
            cpu_pkg::ST_LOAD_WAIT: begin
                next_state = cpu_pkg::ST_LOAD_DATA;
            end
            // Read data valid
            cpu_pkg::ST_LOAD_DATA: begin
                dp_op       = cpu_pkg::DP_LOAD_BUS;
                offset_step = 1'b1;
                next_state  = cpu_pkg::ST_CHOOSE_OP;
            end
            cpu_pkg::ST_IMMEDIATE: begin
                dp_op      = cpu_pkg::DP_LOAD_IMM;
                pc_op      = cpu_pkg::PC_PLUS_TWO;
                next_state = cpu_pkg::ST_FETCH;
            end
            // Strobe is registered, so it shows during the following fetch wait
            cpu_pkg::ST_STORE: begin
                dp_op      = cpu_pkg::DP_STORE;
                pc_op      = cpu_pkg::PC_PLUS_TWO;
                next_state = cpu_pkg::ST_FETCH;
            end
            // ALU result from the choose-op opcode
            cpu_pkg::ST_MATH: begin
                dp_op      = cpu_pkg::DP_ALU;
                pc_op      = cpu_pkg::PC_PLUS_ONE;
                next_state = cpu_pkg::ST_FETCH;
            end
            // Compare result of 1 takes the branch
            cpu_pkg::ST_BRANCH_CHECK: begin
                if (alu_result == 8'h01) begin
                    next_state = cpu_pkg::ST_BRANCH_TAKEN;
                end else begin
                    pc_op      = cpu_pkg::PC_PLUS_TWO;
                    next_state = cpu_pkg::ST_FETCH;
                end
            end
            // Target byte is on the ROM output
            cpu_pkg::ST_BRANCH_TAKEN: begin
                pc_op      = cpu_pkg::PC_LOAD_ROM;
                next_state = cpu_pkg::ST_FETCH;
            end
            cpu_pkg::ST_GOTO: begin
                next_state = cpu_pkg::ST_BRANCH_TAKEN;
            end
            // Remember the instruction after the call, then jump
            cpu_pkg::ST_CALL: begin
                save_context = 1'b1;
                next_state   = cpu_pkg::ST_BRANCH_TAKEN;
            end
            cpu_pkg::ST_RETURN: begin
                pc_op      = cpu_pkg::PC_LOAD_CONTEXT;
                next_state = cpu_pkg::ST_FETCH;
            end
            default: begin
                next_state = cpu_pkg::ST_FETCH;
            end
        endcase
    end

    // At most one line acknowledged at a time
    a_ack_onehot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0(irq_ack));

    // Ack only ever follows an idle cycle
    a_ack_from_idle: assert property (@(posedge CLK) disable iff (RESET)
        (irq_ack != 2'b00) |-> ($past(state) == cpu_pkg::ST_IDLE));

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  logic           CLK,
    input  logic           RESET,
    // Data bus, split into separate in and out bytes
    input  cpu_pkg::word_t bus_data_in,
    output cpu_pkg::word_t bus_data_out,
    output cpu_pkg::word_t bus_addr,
    output logic           bus_we,
    // Program ROM
    output cpu_pkg::word_t rom_address,
    input  cpu_pkg::word_t rom_data,
    // Interrupt lines, line 0 has priority
    input  logic [1:0]     irq_raise,
    output logic [1:0]     irq_ack
);

    cpu_pkg::pc_op_e pc_op;
    logic            offset_step;
    logic            save_context;
    cpu_pkg::dp_op_e dp_op;
    logic            use_b;
    cpu_pkg::word_t  reg_a;
    cpu_pkg::word_t  reg_b;
    cpu_pkg::word_t  alu_result;

    // Instruction sequencing and interrupt handling
    cpu_control cpu_control_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .rom_data     (rom_data),
        .alu_result   (alu_result),
        .irq_raise    (irq_raise),
        .irq_ack      (irq_ack),
        .pc_op        (pc_op),
        .offset_step  (offset_step),
        .save_context (save_context),
        .dp_op        (dp_op),
        .use_b        (use_b)
    );

    // Fetch address generation
    cpu_pc_unit cpu_pc_unit_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .pc_op        (pc_op),
        .offset_step  (offset_step),
        .save_context (save_context),
        .rom_data     (rom_data),
        .rom_address  (rom_address)
    );

    // Registers A and B plus bus outputs
    cpu_datapath cpu_datapath_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .dp_op        (dp_op),
        .use_b        (use_b),
        .rom_data     (rom_data),
        .bus_data_in  (bus_data_in),
        .alu_result   (alu_result),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .bus_addr     (bus_addr),
        .bus_data_out (bus_data_out),
        .bus_we       (bus_we)
    );

    // Opcode is the high nibble of the byte currently on the ROM output
    cpu_alu cpu_alu_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .reg_a  (reg_a),
        .reg_b  (reg_b),
        .alu_op (cpu_pkg::alu_op_e'(rom_data[7:4])),
        .result (alu_result)
    );

endmodule

`default_nettype wire

// ==== verification/cpu_ref_model.svh ====
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH
`default_nettype none

// Model state, kept across threads like the core's registers
cpu_pkg::word_t model_ram [256];
cpu_pkg::word_t model_a;
cpu_pkg::word_t model_b;
cpu_pkg::word_t model_ctx;

// ALU operations by opcode nibble
function automatic cpu_pkg::word_t model_alu(input logic [3:0] op);
    case (op)
        cpu_pkg::ALU_ADD:   return model_a + model_b;
        cpu_pkg::ALU_SUB:   return model_a - model_b;
        cpu_pkg::ALU_AND:   return model_a & model_b;
        cpu_pkg::ALU_OR:    return model_a | model_b;
        cpu_pkg::ALU_XOR:   return model_a ^ model_b;
        cpu_pkg::ALU_SHL_A: return {model_a[6:0], 1'b0};
        cpu_pkg::ALU_SHR_A: return {1'b0, model_a[7:1]};
        cpu_pkg::ALU_INC_A: return model_a + 8'd1;
        cpu_pkg::ALU_INC_B: return model_b + 8'd1;
        cpu_pkg::ALU_DEC_A: return model_a - 8'd1;
        cpu_pkg::ALU_DEC_B: return model_b - 8'd1;
        cpu_pkg::ALU_EQ:    return (model_a == model_b) ? 8'd1 : 8'd0;
        cpu_pkg::ALU_GT:    return (model_a > model_b) ? 8'd1 : 8'd0;
        cpu_pkg::ALU_LT:    return (model_a < model_b) ? 8'd1 : 8'd0;
        cpu_pkg::ALU_INV_A: return ~model_a;
        default:            return 8'd0;
    endcase
endfunction

// Runs one thread from start until idle
task automatic model_thread(input cpu_pkg::word_t start);
    cpu_pkg::word_t pc;
    cpu_pkg::word_t op;
    cpu_pkg::word_t opd;
    cpu_pkg::word_t val;
    bit             done;
    int             steps;
    pc = start;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
        op = rom[pc];
        opd = rom[pc + 8'd1];
        val = op[0] ? model_b : model_a;
        case (op[3:0])
            cpu_pkg::INSTR_LOAD_A, cpu_pkg::INSTR_LOAD_B: begin
                if (op[7:4] == cpu_pkg::IMM_MARK) begin
                    val = opd;
                end else begin
                    exp_ld_addr.push_back(opd);
                    val = model_ram[opd];
                end
                pc = pc + 8'd2;
            end
            cpu_pkg::INSTR_STORE_A, cpu_pkg::INSTR_STORE_B: begin
                exp_st_addr.push_back(opd);
                exp_st_data.push_back(val);
                model_ram[opd] = val;
                pc = pc + 8'd2;
            end
            cpu_pkg::INSTR_MATH_A, cpu_pkg::INSTR_MATH_B: begin
                val = model_alu(op[7:4]);
                pc = pc + 8'd1;
            end
            // Taken only on a result of exactly 1
            cpu_pkg::INSTR_BRANCH: pc = (model_alu(op[7:4]) == 8'd1) ? opd : pc + 8'd2;
            cpu_pkg::INSTR_GOTO:   pc = opd;
            cpu_pkg::INSTR_CALL: begin
                model_ctx = pc + 8'd2;
                pc = opd;
            end
            cpu_pkg::INSTR_RETURN: pc = model_ctx;
            default:               done = 1'b1;
        endcase
        // Only loads and math write back
        if (op[3:0] inside {4'h0, 4'h1, 4'h4, 4'h5}) begin
            if (op[0]) begin
                model_b = val;
            end else begin
                model_a = val;
            end
        end
        steps++;
    end
    if (!done) abort_run("reference model ran past its step limit");
endtask

// Main program, then line 0 thread, then line 1 thread
task automatic predict_bus_traffic();
    model_ram = ram;
    model_a = 8'h00;
    model_b = 8'h00;
    model_ctx = 8'h00;
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_ld_addr.delete();
    exp_ack.delete();
    model_thread(8'h00);
    exp_ack.push_back(2'b01);
    model_thread(rom[cpu_pkg::IRQ_VECTOR_A]);
    exp_ack.push_back(2'b10);
    model_thread(rom[cpu_pkg::IRQ_VECTOR_B]);
endtask

`default_nettype wire
`endif

// ==== verification/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    logic           CLK;
    logic           RESET;
    cpu_pkg::word_t bus_data_in;
    cpu_pkg::word_t bus_data_out;
    cpu_pkg::word_t bus_addr;
    logic           bus_we;
    cpu_pkg::word_t rom_address;
    cpu_pkg::word_t rom_data;
    logic [1:0]     irq_raise;
    logic [1:0]     irq_ack;

    cpu_pkg::word_t rom [256];
    cpu_pkg::word_t ram [256];
    cpu_pkg::word_t rom_addr_q;
    cpu_pkg::word_t ram_addr_q;
    cpu_pkg::word_t gen_addr;
    // Expected traffic from the model
    cpu_pkg::word_t exp_st_addr [$];
    cpu_pkg::word_t exp_st_data [$];
    cpu_pkg::word_t exp_ld_addr [$];
    logic [1:0]     exp_ack [$];
    logic           prev_we;
    logic [1:0]     prev_ack;
    logic [1:0]     acked;
    int             cycles;

    cpu_top cpu_top_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .bus_addr     (bus_addr),
        .bus_we       (bus_we),
        .rom_address  (rom_address),
        .rom_data     (rom_data),
        .irq_raise    (irq_raise),
        .irq_ack      (irq_ack)
    );

    always #4 CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic put_byte(input cpu_pkg::word_t value);
        rom[gen_addr] = value;
        gen_addr = gen_addr + 8'd1;
    endtask

    // Stores land below E0 only
    task automatic put_store();
        put_byte({7'b0000_001, 1'($urandom_range(0, 1))});
        put_byte(8'($urandom_range(0, 8'hDF)));
    endtask

    // Random forward-only code, ends in idle or return
    task automatic build_segment(input cpu_pkg::word_t start, input cpu_pkg::word_t limit,
                                 input bit in_sub);
        int             kind;
        logic           sel;
        logic [3:0]     op;
        cpu_pkg::word_t patch_at;
        gen_addr = start;
        while (gen_addr < limit) begin
            kind = $urandom_range(0, 9);
            sel = 1'($urandom_range(0, 1));
            op = 4'($urandom_range(0, 14));
            if (kind == 9 && in_sub) kind = 4;
            case (kind)
                0: begin
                    put_byte({cpu_pkg::IMM_MARK, 3'b000, sel});
                    put_byte(8'($urandom));
                end
                // Load address never FF, so it shows on the bus
                1: begin
                    put_byte({7'b0, sel});
                    put_byte(8'($urandom_range(0, 8'hFE)));
                end
                2, 3: put_store();
                4, 5, 6: put_byte({op, 3'b010, sel});
                // Branch or goto over one store
                7, 8: begin
                    if (kind == 7 && $urandom_range(0, 1)) op = 4'($urandom_range(11, 13));
                    put_byte((kind == 7) ? {op, 4'h6} : 8'h07);
                    patch_at = gen_addr;
                    put_byte(8'h00);
                    put_store();
                    rom[patch_at] = gen_addr;
                end
                default: begin
                    put_byte(8'h09);
                    put_byte(8'hC0);
                end
            endcase
        end
        put_byte(in_sub ? 8'h0A : 8'h08);
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            rom[i] = 8'(i) ^ 8'hA5;
            ram[i] = 8'($urandom);
        end
        build_segment(8'h00, 8'h3A, 1'b0);
        build_segment(8'h40, 8'h7A, 1'b0);
        build_segment(8'h80, 8'hBA, 1'b0);
        build_segment(8'hC0, 8'hF8, 1'b1);
        rom[cpu_pkg::IRQ_VECTOR_A] = 8'h40;
        rom[cpu_pkg::IRQ_VECTOR_B] = 8'h80;
    endtask

    // Memories sample the address mid-cycle and answer after the edge
    always @(negedge CLK) begin
        rom_addr_q = rom_address;
        ram_addr_q = bus_addr;
    end

    always @(posedge CLK) begin
        #1;
        rom_data = rom[rom_addr_q];
        bus_data_in = ram[ram_addr_q];
    end

    // Bus and ack monitor
    always @(negedge CLK) begin
        if (!RESET) begin
            if (bus_we) begin
                assert (!prev_we) else abort_run("bus_we stayed high for two cycles");
                assert (exp_st_addr.size() > 0) else abort_run("store with none expected");
                assert (bus_addr == exp_st_addr[0] && bus_data_out == exp_st_data[0])
                    else abort_run($sformatf("Fail at %0t ns: store %h to %h, expected %h to %h",
                        $time, bus_data_out, bus_addr, exp_st_data[0], exp_st_addr[0]));
                ram[bus_addr] = bus_data_out;
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
            end else if (bus_addr != cpu_pkg::RESET_BUS_ADDR) begin
                assert (exp_ld_addr.size() > 0) else abort_run("bus address with no load due");
                assert (bus_addr == exp_ld_addr[0])
                    else abort_run($sformatf("Fail at %0t ns: load address %h, expected %h",
                        $time, bus_addr, exp_ld_addr[0]));
                void'(exp_ld_addr.pop_front());
            end
            if (irq_ack != 2'b00) begin
                assert (prev_ack == 2'b00) else abort_run("irq_ack stayed high for two cycles");
                assert (exp_ack.size() > 0) else abort_run("interrupt acknowledged too often");
                assert (irq_ack == exp_ack[0])
                    else abort_run($sformatf("Fail at %0t ns: irq_ack %b, expected %b",
                        $time, irq_ack, exp_ack[0]));
                acked = acked | irq_ack;
                void'(exp_ack.pop_front());
            end
        end
        prev_we = bus_we;
        prev_ack = irq_ack;
    end

    initial begin
        void'($urandom(32'h9368c233));
        CLK = 1'b0;
        RESET = 1'b1;
        irq_raise = 2'b00;
        rom_data = 8'h00;
        bus_data_in = 8'h00;
        prev_we = 1'b0;
        prev_ack = 2'b00;
        for (int prog = 0; prog < 4; prog++) begin
            @(posedge CLK);
            #1;
            RESET = 1'b1;
            irq_raise = 2'b00;
            acked = 2'b00;
            build_program();
            predict_bus_traffic();
            repeat (16) @(posedge CLK);
            #1;
            assert (!bus_we && irq_ack == 2'b00 && bus_addr == cpu_pkg::RESET_BUS_ADDR)
                else abort_run($sformatf("Fail at %0t ns: outputs not idle after reset", $time));
            RESET = 1'b0;
            // Both lines wait from the start, each drops once acknowledged
            irq_raise = 2'b11;
            cycles = 0;
            while ((exp_st_addr.size() + exp_ld_addr.size() + exp_ack.size()) > 0
                   && cycles < 20000) begin
                @(posedge CLK);
                #1;
                irq_raise = irq_raise & ~acked;
                cycles++;
            end
            assert ((exp_st_addr.size() + exp_ld_addr.size() + exp_ack.size()) == 0)
                else abort_run("timed out waiting for the expected bus traffic");
            // Quiet window, any late store trips the monitor
            repeat (100) @(posedge CLK);
        end
        $display("test passed");
        $finish;
    end

`include "cpu_ref_model.svh"

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verification
src/cpu_pkg.sv
src/cpu_alu.sv
src/cpu_pc_unit.sv
src/cpu_datapath.sv
src/cpu_control.sv
src/cpu_top.sv
verification/cpu_tb.sv

// ==== Makefile ====
SIM_LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module cpu_tb -f files.f

sim:
	verilator --binary --timing --assert -j 0 --top-module cpu_tb -f files.f \
		-Mdir obj_dir -o cpu_tb_sim
	./obj_dir/cpu_tb_sim | tee $(SIM_LOG)
	grep -q "^test passed$$" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
